//--- build.f
logic/rv_pkg.sv
logic/rv_fetch.sv
logic/rv_decoder.sv
logic/rv_regfile.sv
logic/rv_execute.sv
logic/rv_pipeline.sv
sim/tb_clock_gen.sv
sim/tb_rv_pipeline.sv

//--- logic/rv_decoder.sv
`timescale 1ns/1ps

module rv_decoder (
    input  logic             clk_i,
    input  logic             arst_n_i,
    input  rv_pkg::word_t    instr_i,
    input  logic             valid_i,
    output logic             valid_o,
    output rv_pkg::alu_op_t  alu_op_o,
    output logic             use_imm_o,
    output rv_pkg::word_t    imm_o,
    output rv_pkg::reg_idx_t rd_o,
    output rv_pkg::reg_idx_t rs1_o,
    output rv_pkg::reg_idx_t rs2_o
);

    rv_pkg::opcode_t opcode;
    logic [2:0]      funct3;
    logic            funct7_b5;
    logic            supported;
    rv_pkg::alu_op_t alu_op;
    logic            use_imm;
    rv_pkg::word_t   imm;
    rv_pkg::alu_op_t f3_op;

    // instruction fields
    assign opcode    = instr_i[6:0];
    assign funct3    = instr_i[14:12];
    assign funct7_b5 = instr_i[30];

    // funct3 to alu op, bit 30 picks sub and sra
    always_comb begin
        case (funct3)
            rv_pkg::F3_ADD:  f3_op = rv_pkg::ALU_ADD;
            rv_pkg::F3_SLL:  f3_op = rv_pkg::ALU_SLL;
            rv_pkg::F3_SLT:  f3_op = rv_pkg::ALU_SLT;
            rv_pkg::F3_SLTU: f3_op = rv_pkg::ALU_SLTU;
            rv_pkg::F3_XOR:  f3_op = rv_pkg::ALU_XOR;
            rv_pkg::F3_SR:   f3_op = funct7_b5 ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
            rv_pkg::F3_OR:   f3_op = rv_pkg::ALU_OR;
            default:         f3_op = rv_pkg::ALU_AND;
        endcase
    end

    always_comb begin
        supported = 1'b1;
        alu_op    = f3_op;
        use_imm   = 1'b0;
        // i immediate, sign extended
        imm       = {{(rv_pkg::XLEN-12){instr_i[31]}}, instr_i[31:20]};
        case (opcode)
            rv_pkg::OPC_OP: begin
                // bit 30 only means sub on the add slot
                if (funct3 == rv_pkg::F3_ADD && funct7_b5) begin
                    alu_op = rv_pkg::ALU_SUB;
                end
            end
            rv_pkg::OPC_OP_IMM: begin
                use_imm = 1'b1;
                // shift amount only, drop the funct7 bits
                if (funct3 == rv_pkg::F3_SLL || funct3 == rv_pkg::F3_SR) begin
                    imm = {{(rv_pkg::XLEN-5){1'b0}}, instr_i[24:20]};
                end
            end
            rv_pkg::OPC_LUI: begin
                alu_op  = rv_pkg::ALU_PASS_B;
                use_imm = 1'b1;
                // u immediate, low 12 bits zero
                imm     = {instr_i[31:12], 12'b0};
            end
            default: begin
                // unknown opcode retires as a bubble
                supported = 1'b0;
            end
        endcase
    end

    // execute stage valid
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_o <= 1'b0;
        end else begin
            valid_o <= valid_i && supported;
        end
    end

    // execute stage payload
    always_ff @(posedge clk_i) begin
        alu_op_o  <= alu_op;
        use_imm_o <= use_imm;
        imm_o     <= imm;
        rd_o      <= instr_i[11:7];
        rs1_o     <= instr_i[19:15];
        rs2_o     <= instr_i[24:20];
    end

endmodule

//--- logic/rv_execute.sv
`timescale 1ns/1ps

module rv_execute (
    input  logic             clk_i,
    input  logic             arst_n_i,
    input  logic             valid_i,
    input  rv_pkg::alu_op_t  alu_op_i,
    input  logic             use_imm_i,
    input  rv_pkg::word_t    imm_i,
    input  rv_pkg::reg_idx_t rd_i,
    input  rv_pkg::reg_idx_t rs1_i,
    input  rv_pkg::reg_idx_t rs2_i,
    input  rv_pkg::word_t    rs1_val_i,
    input  rv_pkg::word_t    rs2_val_i,
    output logic             wb_valid_o,
    output rv_pkg::reg_idx_t wb_rd_o,
    output rv_pkg::word_t    wb_data_o
);

    logic          fwd_rs1;
    logic          fwd_rs2;
    rv_pkg::word_t rs1_val;
    rv_pkg::word_t rs2_val;
    rv_pkg::word_t op_a;
    rv_pkg::word_t op_b;
    logic [4:0]    shamt;
    rv_pkg::word_t alu_res;

    // writeback register as bypass source, x0 never bypassed
    assign fwd_rs1 = wb_valid_o && (wb_rd_o == rs1_i) && (rs1_i != '0);
    assign fwd_rs2 = wb_valid_o && (wb_rd_o == rs2_i) && (rs2_i != '0);

    assign rs1_val = fwd_rs1 ? wb_data_o : rs1_val_i;
    assign rs2_val = fwd_rs2 ? wb_data_o : rs2_val_i;

    // operand b is immediate or rs2
    assign op_a  = rs1_val;
    assign op_b  = use_imm_i ? imm_i : rs2_val;
    assign shamt = op_b[4:0];

    // alu
    always_comb begin
        case (alu_op_i)
            rv_pkg::ALU_ADD: begin
                alu_res = op_a + op_b;
            end
            rv_pkg::ALU_SUB: begin
                alu_res = op_a - op_b;
            end
            rv_pkg::ALU_SLL: begin
                alu_res = op_a << shamt;
            end
            rv_pkg::ALU_SLT: begin
                // signed compare
                alu_res = {31'b0, $signed(op_a) < $signed(op_b)};
            end
            rv_pkg::ALU_SLTU: begin
                alu_res = {31'b0, op_a < op_b};
            end
            rv_pkg::ALU_XOR: begin
                alu_res = op_a ^ op_b;
            end
            rv_pkg::ALU_SRL: begin
                alu_res = op_a >> shamt;
            end
            rv_pkg::ALU_SRA: begin
                // sign bit fills from the left
                alu_res = rv_pkg::word_t'($signed(op_a) >>> shamt);
            end
            rv_pkg::ALU_OR: begin
                alu_res = op_a | op_b;
            end
            rv_pkg::ALU_AND: begin
                alu_res = op_a & op_b;
            end
            rv_pkg::ALU_PASS_B: begin
                alu_res = op_b;
            end
            default: begin
                alu_res = '0;
            end
        endcase
    end

    // writeback valid
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wb_valid_o <= 1'b0;
        end else begin
            wb_valid_o <= valid_i;
        end
    end

    // writeback payload, only looked at with wb_valid_o
    always_ff @(posedge clk_i) begin
        wb_rd_o   <= rd_i;
        wb_data_o <= alu_res;
    end

endmodule

//--- logic/rv_fetch.sv
`timescale 1ns/1ps

module rv_fetch #(
    parameter rv_pkg::word_t RESET_PC = '0
) (
    input  logic          clk_i,
    input  logic          arst_n_i,
    input  rv_pkg::word_t instr_rdata_i,
    output rv_pkg::word_t instr_addr_o,
    output rv_pkg::word_t instr_o,
    output logic          valid_o
);

    // no branches, so the pc only ever steps by one word
    localparam rv_pkg::word_t PC_STEP = 4;

    rv_pkg::word_t pc_q;

    // program counter
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            pc_q <= RESET_PC;
        end else begin
            pc_q <= pc_q + PC_STEP;
        end
    end

    // memory answers from this address in the same cycle
    assign instr_addr_o = pc_q;

    // decode stage valid, first word lands one cycle after reset
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_o <= 1'b0;
        end else begin
            valid_o <= 1'b1;
        end
    end

    // fetched word into decode
    always_ff @(posedge clk_i) begin
        instr_o <= instr_rdata_i;
    end

endmodule

//--- logic/rv_pipeline.sv
`timescale 1ns/1ps

module rv_pipeline #(
    parameter rv_pkg::word_t RESET_PC = '0
) (
    input  logic             clk_i,
    input  logic             arst_n_i,
    input  rv_pkg::word_t    instr_rdata_i,
    output rv_pkg::word_t    instr_addr_o,
    output logic             wb_valid_o,
    output rv_pkg::reg_idx_t wb_rd_o,
    output rv_pkg::word_t    wb_data_o
);

    // fetch to decode
    rv_pkg::word_t    if_instr;
    logic             if_valid;

    // decode to execute
    logic             ex_valid;
    rv_pkg::alu_op_t  ex_alu_op;
    logic             ex_use_imm;
    rv_pkg::word_t    ex_imm;
    rv_pkg::reg_idx_t ex_rd;
    rv_pkg::reg_idx_t ex_rs1;
    rv_pkg::reg_idx_t ex_rs2;
    rv_pkg::word_t    ex_rs1_val;
    rv_pkg::word_t    ex_rs2_val;

    rv_fetch #(
        .RESET_PC(RESET_PC)
    ) u_fetch (
        .clk_i         (clk_i),
        .arst_n_i      (arst_n_i),
        .instr_rdata_i (instr_rdata_i),
        .instr_addr_o  (instr_addr_o),
        .instr_o       (if_instr),
        .valid_o       (if_valid)
    );

    // decoder and register file both work on the fetched word
    rv_decoder u_decoder (
        .clk_i     (clk_i),
        .arst_n_i  (arst_n_i),
        .instr_i   (if_instr),
        .valid_i   (if_valid),
        .valid_o   (ex_valid),
        .alu_op_o  (ex_alu_op),
        .use_imm_o (ex_use_imm),
        .imm_o     (ex_imm),
        .rd_o      (ex_rd),
        .rs1_o     (ex_rs1),
        .rs2_o     (ex_rs2)
    );

    // writeback report doubles as the register file write port
    rv_regfile u_regfile (
        .clk_i     (clk_i),
        .arst_n_i  (arst_n_i),
        .instr_i   (if_instr),
        .we_i      (wb_valid_o),
        .waddr_i   (wb_rd_o),
        .wdata_i   (wb_data_o),
        .rs1_val_o (ex_rs1_val),
        .rs2_val_o (ex_rs2_val)
    );

    rv_execute u_execute (
        .clk_i      (clk_i),
        .arst_n_i   (arst_n_i),
        .valid_i    (ex_valid),
        .alu_op_i   (ex_alu_op),
        .use_imm_i  (ex_use_imm),
        .imm_i      (ex_imm),
        .rd_i       (ex_rd),
        .rs1_i      (ex_rs1),
        .rs2_i      (ex_rs2),
        .rs1_val_i  (ex_rs1_val),
        .rs2_val_i  (ex_rs2_val),
        .wb_valid_o (wb_valid_o),
        .wb_rd_o    (wb_rd_o),
        .wb_data_o  (wb_data_o)
    );

endmodule

//--- logic/rv_pkg.sv
package rv_pkg;

    // RV32I fixes the word width
    localparam int XLEN = 32;

    // data word, instruction word or byte address
    typedef logic [XLEN-1:0] word_t;

    // architectural register index, x0 to x31
    typedef logic [4:0] reg_idx_t;

    // major opcode, instr[6:0]
    typedef logic [6:0] opcode_t;

    // alu operation select
    typedef logic [3:0] alu_op_t;

    // alu op codes
    localparam alu_op_t ALU_ADD    = 4'd0;
    localparam alu_op_t ALU_SUB    = 4'd1;
    localparam alu_op_t ALU_SLL    = 4'd2;
    localparam alu_op_t ALU_SLT    = 4'd3;
    localparam alu_op_t ALU_SLTU   = 4'd4;
    localparam alu_op_t ALU_XOR    = 4'd5;
    localparam alu_op_t ALU_SRL    = 4'd6;
    localparam alu_op_t ALU_SRA    = 4'd7;
    localparam alu_op_t ALU_OR     = 4'd8;
    localparam alu_op_t ALU_AND    = 4'd9;
    // operand b straight through, used by lui
    localparam alu_op_t ALU_PASS_B = 4'd10;

    // register-register alu group
    localparam opcode_t OPC_OP     = 7'b0110011;
    // register-immediate alu group
    localparam opcode_t OPC_OP_IMM = 7'b0010011;
    // load upper immediate
    localparam opcode_t OPC_LUI    = 7'b0110111;

    // funct3 codes shared by op and op-imm
    localparam logic [2:0] F3_ADD  = 3'b000;
    localparam logic [2:0] F3_SLL  = 3'b001;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_SR   = 3'b101;
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;

endpackage

//--- logic/rv_regfile.sv
`timescale 1ns/1ps

module rv_regfile (
    input  logic             clk_i,
    input  logic             arst_n_i,
    input  rv_pkg::word_t    instr_i,
    input  logic             we_i,
    input  rv_pkg::reg_idx_t waddr_i,
    input  rv_pkg::word_t    wdata_i,
    output rv_pkg::word_t    rs1_val_o,
    output rv_pkg::word_t    rs2_val_o
);

    rv_pkg::word_t    regs_q [32];
    rv_pkg::reg_idx_t rs1_idx;
    rv_pkg::reg_idx_t rs2_idx;
    logic             wr_en;

    // source indices straight from the fetched word
    assign rs1_idx = instr_i[19:15];
    assign rs2_idx = instr_i[24:20];

    // writes to x0 are dropped
    assign wr_en = we_i && (waddr_i != '0);

    // same-cycle write wins over the stored value
    // x0 keeps its reset zero since it is never written
    function automatic rv_pkg::word_t read_port(input rv_pkg::reg_idx_t idx);
        if (wr_en && idx == waddr_i) begin
            return wdata_i;
        end
        return regs_q[idx];
    endfunction

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < 32; i++) begin
                regs_q[i] <= '0;
            end
            rs1_val_o <= '0;
            rs2_val_o <= '0;
        end else begin
            if (wr_en) begin
                regs_q[waddr_i] <= wdata_i;
            end
            // operands into execute
            rs1_val_o <= read_port(rs1_idx);
            rs2_val_o <= read_port(rs2_idx);
        end
    end

endmodule

//--- run.sh
#!/bin/sh
# build and run the testbench, pass only if the log holds the pass line
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module tb_rv_pipeline -f build.f -o tb_sim &&
./obj_dir/tb_sim > sim.log 2>&1 ;
cat sim.log &&
grep -qx "STATUS: PASS" sim.log && echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }

//--- sim/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int RESET_CYCLES = 16
) (
    output logic clk_o,
    output logic arst_n_o
);

    // 4 ns period
    initial begin
        clk_o = 1'b0;
        forever begin
            #2 clk_o = ~clk_o;
        end
    end

    // release lands on a rising edge, so the flops still see reset there
    initial begin
        arst_n_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        arst_n_o <= 1'b1;
    end

endmodule

//--- sim/tb_rv_pipeline.sv
`timescale 1ns/1ps

module tb_rv_pipeline;

    localparam rv_pkg::word_t RESET_PC = 32'h0000_0100;
    localparam int MAX_WORDS = 512;

    logic             clk_i;
    logic             arst_n_i;
    rv_pkg::word_t    instr_rdata_i;
    rv_pkg::word_t    instr_addr_o;
    logic             wb_valid_o;
    rv_pkg::reg_idx_t wb_rd_o;
    rv_pkg::word_t    wb_data_o;

    // program and expected retire stream
    rv_pkg::word_t    prog_mem [MAX_WORDS];
    int               prog_len;
    rv_pkg::reg_idx_t exp_rd [MAX_WORDS];
    rv_pkg::word_t    exp_data [MAX_WORDS];
    int               n_exp;
    rv_pkg::word_t    model_rf [32];
    logic [31:0]      lfsr_state;

    // bookkeeping for the checks
    int               cyc;
    int               wb_count;
    rv_pkg::word_t    prev_addr;
    int               reset_errs;
    int               pc_errs;
    int               wb_errs;
    int               other_errs;

    tb_clock_gen #(.RESET_CYCLES(16)) u_clock (
        .clk_o    (clk_i),
        .arst_n_o (arst_n_i)
    );

    rv_pipeline #(.RESET_PC(RESET_PC)) dut (
        .clk_i         (clk_i),
        .arst_n_i      (arst_n_i),
        .instr_rdata_i (instr_rdata_i),
        .instr_addr_o  (instr_addr_o),
        .wb_valid_o    (wb_valid_o),
        .wb_rd_o       (wb_rd_o),
        .wb_data_o     (wb_data_o)
    );

    // taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    // one lfsr step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            r = {r[30:0], lfsr_state[0]};
        end
        return r;
    endfunction

    function automatic logic [4:0] rand_reg();
        logic [31:0] t;
        t = rand_bits(3);
        return t[4:0];
    endfunction

    // beyond the program, opcode 0 words that still carry the whole address
    function automatic rv_pkg::word_t fetch_word(input rv_pkg::word_t addr);
        rv_pkg::word_t off;
        off = addr - RESET_PC;
        if (addr[1:0] == 2'b00 && off < 32'(prog_len * 4)) begin
            return prog_mem[off[10:2]];
        end
        return {addr[31:7] ^ addr[24:0], 7'h00};
    endfunction

    // software model of the kept ISA subset
    task automatic run_model(input rv_pkg::word_t w);
        logic [4:0]    rd;
        logic [4:0]    sh;
        rv_pkg::word_t a;
        rv_pkg::word_t b;
        rv_pkg::word_t res;
        logic          ok;
        rd  = w[11:7];
        a   = model_rf[w[19:15]];
        ok  = 1'b1;
        res = '0;
        if (w[6:0] == 7'b0110011) begin
            b = model_rf[w[24:20]];
            case (w[14:12])
                3'd0: res = w[30] ? a - b : a + b;
                3'd1: res = a << b[4:0];
                3'd2: res = {31'b0, $signed(a) < $signed(b)};
                3'd3: res = {31'b0, a < b};
                3'd4: res = a ^ b;
                3'd5: res = w[30] ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
                3'd6: res = a | b;
                default: res = a & b;
            endcase
        end else if (w[6:0] == 7'b0010011) begin
            b  = {{20{w[31]}}, w[31:20]};
            sh = w[24:20];
            case (w[14:12])
                3'd0: res = a + b;
                3'd1: res = a << sh;
                3'd2: res = {31'b0, $signed(a) < $signed(b)};
                3'd3: res = {31'b0, a < b};
                3'd4: res = a ^ b;
                3'd5: res = w[30] ? 32'($signed(a) >>> sh) : a >> sh;
                3'd6: res = a | b;
                default: res = a & b;
            endcase
        end else if (w[6:0] == 7'b0110111) begin
            res = {w[31:12], 12'b0};
        end else begin
            ok = 1'b0;
        end
        if (ok) begin
            // x0 target still reports, but the register stays zero
            exp_rd[n_exp]   = rd;
            exp_data[n_exp] = res;
            n_exp++;
            if (rd != 5'd0) begin
                model_rf[rd] = res;
            end
        end
    endtask

    task automatic emit(input rv_pkg::word_t w);
        prog_mem[prog_len] = w;
        prog_len++;
        run_model(w);
    endtask

    // op 0..9 is add sub sll slt sltu xor srl sra or and
    task automatic emit_r(input int op, input logic [4:0] rd, input logic [4:0] rs1,
                          input logic [4:0] rs2);
        logic [2:0] f3;
        logic [6:0] f7;
        f7 = (op == 1 || op == 7) ? 7'b0100000 : 7'b0000000;
        case (op)
            0, 1: f3 = 3'd0;
            2: f3 = 3'd1;
            3: f3 = 3'd2;
            4: f3 = 3'd3;
            5: f3 = 3'd4;
            6, 7: f3 = 3'd5;
            8: f3 = 3'd6;
            default: f3 = 3'd7;
        endcase
        emit({f7, rs2, rs1, f3, rd, 7'b0110011});
    endtask

    // k 0..5 addi slti sltiu xori ori andi, 6..8 slli srli srai, 9 lui
    task automatic emit_i(input int k, input logic [4:0] rd, input logic [4:0] rs1,
                          input logic [31:0] r);
        logic [2:0]  f3;
        logic [11:0] imm;
        imm = r[11:0];
        case (k)
            0: f3 = 3'd0;
            1: f3 = 3'd2;
            2: f3 = 3'd3;
            3: f3 = 3'd4;
            4: f3 = 3'd6;
            5: f3 = 3'd7;
            6: f3 = 3'd1;
            default: f3 = 3'd5;
        endcase
        if (k == 6 || k == 7) begin
            imm = {7'b0000000, r[4:0]};
        end else if (k == 8) begin
            imm = {7'b0100000, r[4:0]};
        end
        if (k == 9) begin
            emit({r[31:12], rd, 7'b0110111});
        end else begin
            emit({imm, rs1, f3, rd, 7'b0010011});
        end
    endtask

    task automatic build_program();
        logic [31:0] v;
        logic [4:0]  ri;
        logic [4:0]  prev;
        logic [4:0]  rd;
        prog_len = 0;
        n_exp    = 0;
        for (int i = 0; i < 32; i++) begin
            model_rf[i] = '0;
        end
        // seed x1..x7 with lui/addi pairs
        for (int r = 1; r < 8; r++) begin
            ri = r[4:0];
            v  = rand_bits(32);
            emit({v[31:12], ri, 7'b0110111});
            emit({v[11:0], ri, 3'd0, ri, 7'b0010011});
        end
        // every register-register op, three passes
        for (int p = 0; p < 3; p++) begin
            for (int op = 0; op < 10; op++) begin
                emit_r(op, rand_reg(), rand_reg(), rand_reg());
            end
        end
        // branch opcode
        emit(32'h0000_0063);
        // immediates, shifts and lui
        for (int p = 0; p < 3; p++) begin
            for (int k = 0; k < 10; k++) begin
                emit_i(k, rand_reg(), rand_reg(), rand_bits(32));
            end
        end
        // load opcode
        emit(32'h0000_2003);
        // chain where each rs1 is the previous rd
        prev = 5'd1;
        for (int i = 0; i < 24; i++) begin
            rd = rand_reg();
            if (rd == 5'd0) begin
                rd = 5'd1;
            end
            v = rand_bits(1);
            if (v[0]) begin
                emit_r(i % 10, rd, prev, rand_reg());
            end else begin
                emit_i(i % 9, rd, prev, rand_bits(32));
            end
            prev = rd;
        end
        // x0 target, then reads of x0
        emit_i(0, 5'd0, 5'd3, 32'h0000_0123);
        emit_r(0, 5'd4, 5'd0, 5'd0);
        emit_r(8, 5'd5, 5'd0, 5'd3);
        // jal opcode
        emit(32'h0000_006f);
    endtask

    initial begin
        instr_rdata_i = '0;
        lfsr_state    = 32'h186d;
        reset_errs    = 0;
        pc_errs       = 0;
        wb_errs       = 0;
        other_errs    = 0;
        build_program();
    end

    // memory word for the address the DUT shows in the coming cycle
    always @(posedge clk_i) begin
        if (!arst_n_i) begin
            instr_rdata_i <= fetch_word(RESET_PC);
        end else begin
            instr_rdata_i <= fetch_word(instr_addr_o + 32'd4);
        end
    end

    always @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            cyc      <= 0;
            wb_count <= 0;
        end else begin
            cyc <= cyc + 1;
            if (wb_valid_o) begin
                wb_count <= wb_count + 1;
            end
        end
    end

    always @(posedge clk_i) begin
        prev_addr <= instr_addr_o;
    end

    // pipeline still empty right after reset
    assert property (@(posedge clk_i) disable iff (!arst_n_i) (cyc < 3) |-> !wb_valid_o)
    else begin
        reset_errs++;
        $display("Error: wb_valid_o got %h expected 0 in cycle %0d", $sampled(wb_valid_o),
                 $sampled(cyc));
    end

    assert property (@(posedge clk_i) disable iff (!arst_n_i)
                     (cyc == 0) |-> (instr_addr_o == RESET_PC))
    else begin
        reset_errs++;
        $display("Error: instr_addr_o got %h expected %h", $sampled(instr_addr_o), RESET_PC);
    end

    assert property (@(posedge clk_i) disable iff (!arst_n_i)
                     (cyc != 0) |-> (instr_addr_o == prev_addr + 32'd4))
    else begin
        pc_errs++;
        $display("Error: instr_addr_o got %h expected %h", $sampled(instr_addr_o),
                 $sampled(prev_addr) + 32'd4);
    end

    // no writeback beyond the supported instructions
    assert property (@(posedge clk_i) disable iff (!arst_n_i)
                     wb_valid_o |-> (wb_count < n_exp))
    else begin
        wb_errs++;
        $display("Error: wb_valid_o pulsed after all %0d expected results", n_exp);
    end

    assert property (@(posedge clk_i) disable iff (!arst_n_i)
                     (wb_valid_o && wb_count < n_exp) |-> (wb_rd_o == exp_rd[wb_count]))
    else begin
        wb_errs++;
        $display("Error: wb_rd_o got %h expected %h at result %0d", $sampled(wb_rd_o),
                 exp_rd[$sampled(wb_count)], $sampled(wb_count));
    end

    assert property (@(posedge clk_i) disable iff (!arst_n_i)
                     (wb_valid_o && wb_count < n_exp) |-> (wb_data_o == exp_data[wb_count]))
    else begin
        wb_errs++;
        $display("Error: wb_data_o got %h expected %h at result %0d", $sampled(wb_data_o),
                 exp_data[$sampled(wb_count)], $sampled(wb_count));
    end

    initial begin
        int t;
        int total;
        t = 0;
        while (arst_n_i !== 1'b1 && t < 64) begin
            @(posedge clk_i);
            t++;
        end
        if (arst_n_i !== 1'b1) begin
            $display("reset was never released");
            other_errs++;
        end
        t = 0;
        while (wb_count < n_exp && t < 4 * MAX_WORDS) begin
            @(posedge clk_i);
            t++;
        end
        if (wb_count < n_exp) begin
            $display("timed out with %0d of %0d results retired", wb_count, n_exp);
            other_errs++;
        end
        // trailing unsupported words must stay silent
        repeat (10) @(posedge clk_i);
        assert (wb_count == n_exp)
        else begin
            other_errs++;
            $display("writeback count %0d does not match %0d supported instructions",
                     wb_count, n_exp);
        end
        total = reset_errs + pc_errs + wb_errs + other_errs;
        $display("errors: reset %0d, pc %0d, writeback %0d, other %0d, results %0d",
                 reset_errs, pc_errs, wb_errs, other_errs, wb_count);
        if (total == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule
